/* rtl/exec_pkg.sv */
// Shared definitions for the execute stage.
// Holds the fixed widths, the micro-op encoding and the message structs
// used on the dispatch port, the writeback bus and the squash output.
// Every execute-stage module imports this package.

package exec_pkg;

  // Widths fixed for the whole core
  localparam int seq_num_bits   = 6;
  localparam int phys_addr_bits = 6;

  // ----------------------------------------------------------------------
  // Micro-op encoding
  // ----------------------------------------------------------------------

  // Top bit set for control flow and clear for ALU
  typedef enum logic [3:0] {
    OP_ADD  = 4'b0000,
    OP_SUB  = 4'b0001,
    OP_AND  = 4'b0010,
    OP_OR   = 4'b0011,
    OP_XOR  = 4'b0100,
    OP_SLT  = 4'b0101,
    OP_SLTU = 4'b0110,
    OP_ADDI = 4'b0111,
    OP_BEQ  = 4'b1000,
    OP_BNE  = 4'b1001,
    OP_BLT  = 4'b1010,
    OP_BGE  = 4'b1011,
    OP_BLTU = 4'b1100,
    OP_BGEU = 4'b1101,
    OP_JAL  = 4'b1110,
    OP_JALR = 4'b1111
  } uop_e;

  // Class decode used by the router
  function automatic logic is_cf_uop(uop_e uop);
    return uop[3];
  endfunction

  // Operand 3 as one word read two ways
  typedef union packed {
    logic [31:0] branch_imm;  // Sign-extended branch/jump offset
    logic [31:0] alu_imm;     // Immediate for OP_ADDI
  } op3_u;

  // ----------------------------------------------------------------------
  // Messages
  // ----------------------------------------------------------------------

  // Renamed micro-op from dispatch
  typedef struct packed {
    logic                      val;
    logic [31:0]               pc;
    logic [seq_num_bits-1:0]   seq_num;
    logic [31:0]               op1;
    logic [31:0]               op2;
    op3_u                      op3;
    logic [4:0]                waddr;
    uop_e                      uop;
    logic [phys_addr_bits-1:0] preg;
    logic [phys_addr_bits-1:0] ppreg;
  } dispatch_t;

  // Writeback payload with its valid on a separate wire
  typedef struct packed {
    logic [31:0]               pc;
    logic [seq_num_bits-1:0]   seq_num;
    logic [4:0]                waddr;
    logic                      wen;
    logic [31:0]               wdata;
    logic [phys_addr_bits-1:0] preg;
    logic [phys_addr_bits-1:0] ppreg;
  } wb_t;

  // One-cycle redirect notice without a handshake
  typedef struct packed {
    logic                    val;
    logic [31:0]             target;
    logic [seq_num_bits-1:0] seq_num;
  } squash_t;

endpackage

/* rtl/dispatch_router.sv */
// Steers dispatched micro-ops to the ALU or control-flow unit.
// The payload fans out to both units; only the selected one sees val.
// Ready back to the dispatcher comes from the selected unit.

`timescale 1ns/1ns

module dispatch_router (
  input  exec_pkg::dispatch_t disp,
  output logic                disp_rdy,
  output exec_pkg::dispatch_t alu_disp,
  output exec_pkg::dispatch_t cf_disp,
  input  logic                alu_rdy,
  input  logic                cf_rdy
);

  import exec_pkg::*;

  // Class of the incoming micro-op
  logic to_cf;

  assign to_cf = is_cf_uop(disp.uop);

  always_comb begin
    // Same payload to both units
    alu_disp = disp;
    cf_disp  = disp;
    // Valid only toward the selected unit
    alu_disp.val = disp.val & ~to_cf;
    cf_disp.val  = disp.val & to_cf;
  end

  // Selected unit's ready goes back
  assign disp_rdy = to_cf ? cf_rdy : alu_rdy;

endmodule

/* rtl/alu_unit.sv */
// One-stage integer execute unit.
// Accepts an ALU micro-op, holds it in a register and offers the result
// on its writeback port until the arbiter takes it. A new micro-op can
// enter in the same cycle the held result leaves.

`timescale 1ns/1ns

module alu_unit (
  input  logic                clk,
  input  logic                rst,
  input  exec_pkg::dispatch_t disp,
  output logic                disp_rdy,
  output logic                wb_val,
  output exec_pkg::wb_t       wb,
  input  logic                wb_rdy
);

  import exec_pkg::*;

  // ----------------------------------------------------------------------
  // Held micro-op
  // ----------------------------------------------------------------------

  logic      held_val;
  dispatch_t held;
  logic      disp_xfer;
  logic      wb_xfer;

  assign disp_xfer = disp.val & disp_rdy;
  assign wb_xfer   = wb_val & wb_rdy;

  // Room when empty or when the held result leaves now
  assign disp_rdy = wb_rdy | ~held_val;

  // Valid tracking
  always_ff @(posedge clk) begin
    if (rst) begin
      held_val <= 1'b0;
    end else if (disp_xfer) begin
      held_val <= 1'b1;
    end else if (wb_xfer) begin
      held_val <= 1'b0;
    end
  end

  // Payload only loads on accept
  always_ff @(posedge clk) begin
    if (disp_xfer) begin
      held <= disp;
    end
  end

  // ----------------------------------------------------------------------
  // Compute from the register
  // ----------------------------------------------------------------------

  logic [31:0] opnd_b;
  logic [31:0] result;

  // Immediate form replaces operand 2
  assign opnd_b = (held.uop == OP_ADDI) ? held.op3.alu_imm : held.op2;

  always_comb begin
    case (held.uop)
      OP_ADD, OP_ADDI: result = held.op1 + opnd_b;
      OP_SUB:          result = held.op1 - opnd_b;
      OP_AND:          result = held.op1 & opnd_b;
      OP_OR:           result = held.op1 | opnd_b;
      OP_XOR:          result = held.op1 ^ opnd_b;
      // Signed compare
      OP_SLT:          result = {31'b0, $signed(held.op1) < $signed(opnd_b)};
      // Unsigned compare
      OP_SLTU:         result = {31'b0, held.op1 < opnd_b};
      default:         result = 32'b0;
    endcase
  end

  // ----------------------------------------------------------------------
  // Writeback
  // ----------------------------------------------------------------------

  assign wb_val = held_val;

  always_comb begin
    wb.pc      = held.pc;
    wb.seq_num = held.seq_num;
    wb.waddr   = held.waddr;
    // Every ALU op writes a register
    wb.wen     = 1'b1;
    wb.wdata   = result;
    wb.preg    = held.preg;
    wb.ppreg   = held.ppreg;
  end

  // Stalled result stays put until taken
  assert property (@(posedge clk) disable iff (rst)
    wb_val && !wb_rdy |=> wb_val && $stable(wb))
    else $error("alu result changed while stalled");

endmodule

/* rtl/control_flow_unit.sv */
// One-stage branch and jump unit.
// Resolves the six conditional branches plus JAL and JALR from a held
// micro-op, writes the link value for jumps and raises a one-cycle
// squash with the redirect target when the micro-op changes the flow.
// JAL never squashes since the front end already redirected it.

`timescale 1ns/1ns

module control_flow_unit (
  input  logic                clk,
  input  logic                rst,
  input  exec_pkg::dispatch_t disp,
  output logic                disp_rdy,
  output logic                wb_val,
  output exec_pkg::wb_t       wb,
  input  logic                wb_rdy,
  output exec_pkg::squash_t   squash
);

  import exec_pkg::*;

  // ----------------------------------------------------------------------
  // Held micro-op
  // ----------------------------------------------------------------------

  logic      held_val;
  dispatch_t held;
  logic      disp_xfer;
  logic      wb_xfer;

  assign disp_xfer = disp.val & disp_rdy;
  assign wb_xfer   = wb_val & wb_rdy;

  // Free slot or slot freed this cycle
  assign disp_rdy = wb_rdy | ~held_val;

  always_ff @(posedge clk) begin
    if (rst) begin
      held_val <= 1'b0;
    end else if (disp_xfer) begin
      held_val <= 1'b1;
    end else if (wb_xfer) begin
      held_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (disp_xfer) begin
      held <= disp;
    end
  end

  // ----------------------------------------------------------------------
  // Redirect decision
  // ----------------------------------------------------------------------

  logic        redirect;
  logic [31:0] br_target;
  logic [31:0] jalr_target;

  always_comb begin
    case (held.uop)
      OP_BEQ:  redirect = (held.op1 == held.op2);
      OP_BNE:  redirect = (held.op1 != held.op2);
      OP_BLT:  redirect = ($signed(held.op1) < $signed(held.op2));
      OP_BGE:  redirect = ($signed(held.op1) >= $signed(held.op2));
      OP_BLTU: redirect = (held.op1 < held.op2);
      OP_BGEU: redirect = (held.op1 >= held.op2);
      // Target depends on a register the front end cannot read
      OP_JALR: redirect = 1'b1;
      // Already redirected upstream
      OP_JAL:  redirect = 1'b0;
      default: redirect = 1'b0;
    endcase
  end

  assign br_target   = held.pc + held.op3.branch_imm;
  // JALR clears bit 0 of the sum
  assign jalr_target = (held.op1 + held.op3.branch_imm) & ~32'd1;

  // ----------------------------------------------------------------------
  // Squash in the first cycle after accept only
  // ----------------------------------------------------------------------

  // Set one cycle after accept and cleared by the next accept
  logic squash_sent;

  always_ff @(posedge clk) begin
    if (rst) begin
      squash_sent <= 1'b0;
    end else if (disp_xfer) begin
      squash_sent <= 1'b0;
    end else begin
      squash_sent <= 1'b1;
    end
  end

  always_comb begin
    squash.val     = held_val & redirect & ~squash_sent;
    squash.target  = (held.uop == OP_JALR) ? jalr_target : br_target;
    squash.seq_num = held.seq_num;
  end

  // ----------------------------------------------------------------------
  // Writeback
  // ----------------------------------------------------------------------

  assign wb_val = held_val;

  always_comb begin
    wb.pc      = held.pc;
    wb.seq_num = held.seq_num;
    wb.waddr   = held.waddr;
    // Link register write for jumps only
    wb.wen     = (held.uop == OP_JAL) || (held.uop == OP_JALR);
    wb.wdata   = held.pc + 32'd4;
    wb.preg    = held.preg;
    wb.ppreg   = held.ppreg;
  end

endmodule

/* rtl/wb_arbiter.sv */
// Round-robin arbiter for the shared writeback bus.
// Two units request with val; one is granted per cycle and only that one
// sees the bus ready. After a transfer the other unit gets priority.

`timescale 1ns/1ns

module wb_arbiter (
  input  logic          clk,
  input  logic          rst,
  input  logic          alu_val,
  input  logic          cf_val,
  input  exec_pkg::wb_t alu_wb,
  input  exec_pkg::wb_t cf_wb,
  output logic          alu_rdy,
  output logic          cf_rdy,
  output logic          wb_val,
  output exec_pkg::wb_t wb,
  input  logic          wb_rdy
);

  // ----------------------------------------------------------------------
  // Priority state
  // ----------------------------------------------------------------------

  // 0 favours the ALU unit, 1 the control-flow unit
  logic prio_cf;
  logic grant_alu;
  logic grant_cf;
  logic xfer;

  // CF wins when favoured or when ALU has nothing
  assign grant_cf  = cf_val & (prio_cf | ~alu_val);
  assign grant_alu = alu_val & ~grant_cf;

  assign xfer = wb_val & wb_rdy;

  // Winner of a transfer gives priority to the other unit
  always_ff @(posedge clk) begin
    if (rst) begin
      prio_cf <= 1'b0;
    end else if (xfer) begin
      prio_cf <= grant_alu;
    end
  end

  // ----------------------------------------------------------------------
  // Bus mux
  // ----------------------------------------------------------------------

  assign wb_val = alu_val | cf_val;

  always_comb begin
    if (grant_cf) begin
      wb = cf_wb;
    end else begin
      wb = alu_wb;
    end
  end

  // Bus ready only reaches the granted unit
  assign alu_rdy = wb_rdy & grant_alu;
  assign cf_rdy  = wb_rdy & grant_cf;

  // A waiting unit wins the cycle after the other one transfers
  assert property (@(posedge clk) disable iff (rst)
    alu_rdy && cf_val |=> grant_cf)
    else $error("control-flow unit skipped after an ALU transfer");

  assert property (@(posedge clk) disable iff (rst)
    cf_rdy && alu_val |=> grant_alu)
    else $error("ALU unit skipped after a control-flow transfer");

endmodule

/* rtl/execute_top.sv */
// Execute stage top level.
// Dispatch enters through the router, the ALU and control-flow units run
// side by side, and their results share one writeback bus.
// Squash notices leave straight from the control-flow unit.

`timescale 1ns/1ns

module execute_top (
  input  logic                clk,
  input  logic                rst,
  input  exec_pkg::dispatch_t disp,
  output logic                disp_rdy,
  output logic                wb_val,
  output exec_pkg::wb_t       wb,
  input  logic                wb_rdy,
  output exec_pkg::squash_t   squash
);

  import exec_pkg::*;

  // Router to units
  dispatch_t alu_disp;
  dispatch_t cf_disp;
  logic      alu_disp_rdy;
  logic      cf_disp_rdy;

  // Units to arbiter
  logic      alu_wb_val;
  logic      cf_wb_val;
  wb_t       alu_wb;
  wb_t       cf_wb;
  logic      alu_wb_rdy;
  logic      cf_wb_rdy;

  dispatch_router dispatch_router_i (
    .disp     (disp),
    .disp_rdy (disp_rdy),
    .alu_disp (alu_disp),
    .cf_disp  (cf_disp),
    .alu_rdy  (alu_disp_rdy),
    .cf_rdy   (cf_disp_rdy)
  );

  alu_unit alu_unit_i (
    .clk      (clk),
    .rst      (rst),
    .disp     (alu_disp),
    .disp_rdy (alu_disp_rdy),
    .wb_val   (alu_wb_val),
    .wb       (alu_wb),
    .wb_rdy   (alu_wb_rdy)
  );

  control_flow_unit control_flow_unit_i (
    .clk      (clk),
    .rst      (rst),
    .disp     (cf_disp),
    .disp_rdy (cf_disp_rdy),
    .wb_val   (cf_wb_val),
    .wb       (cf_wb),
    .wb_rdy   (cf_wb_rdy),
    .squash   (squash)
  );

  wb_arbiter wb_arbiter_i (
    .clk     (clk),
    .rst     (rst),
    .alu_val (alu_wb_val),
    .cf_val  (cf_wb_val),
    .alu_wb  (alu_wb),
    .cf_wb   (cf_wb),
    .alu_rdy (alu_wb_rdy),
    .cf_rdy  (cf_wb_rdy),
    .wb_val  (wb_val),
    .wb      (wb),
    .wb_rdy  (wb_rdy)
  );

endmodule

/* tb/tb_clock_gen.sv */
// Testbench clock source, 40 ns period.
// Instantiated once by the execute-stage testbench.

`timescale 1ns/1ns

module tb_clock_gen (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

endmodule

/* tb/execute_tb.sv */
// Directed testbench for the execute stage.
// Drives micro-ops on the falling edge, records writebacks and squashes
// at the rising edge and checks them against a reference model.

`timescale 1ns/1ns

module execute_tb;

  import exec_pkg::*;

  localparam int n_vec = 6;
  // Budget per test for resets, ALU, branches, jumps, stall and rotation
  localparam int total_cycles = 2 * 20 + 8 * n_vec * 4 + 6 * n_vec * 6 + 8 * 6 + 30 + 3 * 10;

  logic      clk;
  logic      rst;
  dispatch_t disp;
  logic      disp_rdy;
  logic      wb_val;
  wb_t       wb;
  logic      wb_rdy;
  squash_t   squash;

  // Monitor records consumed through read indexes
  wb_t     wb_q[$];
  squash_t sq_q[$];
  int      sq_cyc_q[$];
  int      wb_rd = 0;
  int      sq_rd = 0;
  int      cycle = 0;
  int      cf_acc_cycle = 0;

  logic [31:0]             rng_state = 32'd20;
  logic [seq_num_bits-1:0] next_seq = '0;

  tb_clock_gen tb_clock_gen_i (.clk(clk));

  execute_top execute_top_i (
    .clk      (clk),
    .rst      (rst),
    .disp     (disp),
    .disp_rdy (disp_rdy),
    .wb_val   (wb_val),
    .wb       (wb),
    .wb_rdy   (wb_rdy),
    .squash   (squash)
  );

  // ----------------------------------------------------------------------
  // Failure reporting and watchdog
  // ----------------------------------------------------------------------

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
      abort_run("Stopping after a value mismatch");
    end
  endtask

  initial begin
    #(total_cycles * 4 * 40);
    abort_run("Timeout: the tests did not finish in the expected time");
  end

  // Sampled before the edge updates any register
  always @(posedge clk) begin
    if (!rst) begin
      if (wb_val && wb_rdy) begin
        wb_q.push_back(wb);
      end
      if (squash.val) begin
        sq_q.push_back(squash);
        sq_cyc_q.push_back(cycle);
      end
      // Last accepted control-flow micro-op
      if (disp.val && disp_rdy && is_control_flow(disp.uop)) begin
        cf_acc_cycle = cycle;
      end
    end
    cycle = cycle + 1;
  end

  // ----------------------------------------------------------------------
  // Reference model and stimulus helpers
  // ----------------------------------------------------------------------

  // xorshift32
  function automatic logic [31:0] rand_word();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic is_control_flow(input uop_e op);
    return op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU, OP_JAL, OP_JALR};
  endfunction

  // 13-bit even offset, sign-extended
  function automatic logic [31:0] branch_offset(input logic [31:0] r);
    return {{19{r[12]}}, r[12:1], 1'b0};
  endfunction

  function automatic logic [31:0] alu_model(input uop_e op, input logic [31:0] a,
                                            input logic [31:0] b, input logic [31:0] imm);
    logic [31:0] r;
    case (op)
      OP_ADD:  r = a + b;
      OP_ADDI: r = a + imm;
      OP_SUB:  r = a - b;
      OP_AND:  r = a & b;
      OP_OR:   r = a | b;
      OP_XOR:  r = a ^ b;
      // Signed order by flipping the sign bits
      OP_SLT:  r = ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
      OP_SLTU: r = (a < b) ? 32'd1 : 32'd0;
      default: r = 32'd0;
    endcase
    return r;
  endfunction

  // Returns 1 when the micro-op must squash, with its target
  function automatic logic redirect_model(input dispatch_t d, output logic [31:0] tgt);
    logic        r;
    logic        lt_s;
    logic [31:0] sum;
    lt_s = (d.op1 ^ 32'h8000_0000) < (d.op2 ^ 32'h8000_0000);
    sum  = d.op1 + d.op3.branch_imm;
    tgt  = d.pc + d.op3.branch_imm;
    case (d.uop)
      OP_BEQ:  r = (d.op1 == d.op2);
      OP_BNE:  r = (d.op1 != d.op2);
      OP_BLT:  r = lt_s;
      OP_BGE:  r = !lt_s;
      OP_BLTU: r = (d.op1 < d.op2);
      OP_BGEU: r = !(d.op1 < d.op2);
      OP_JALR: begin
        r   = 1'b1;
        tgt = {sum[31:1], 1'b0};
      end
      default: r = 1'b0;
    endcase
    return r;
  endfunction

  function automatic wb_t model_wb(input dispatch_t d);
    wb_t w;
    w.pc      = d.pc;
    w.seq_num = d.seq_num;
    w.waddr   = d.waddr;
    w.preg    = d.preg;
    w.ppreg   = d.ppreg;
    if (is_control_flow(d.uop)) begin
      // Link value for jumps, nothing for branches
      w.wen   = (d.uop == OP_JAL) || (d.uop == OP_JALR);
      w.wdata = d.pc + 32'd4;
    end else begin
      w.wen   = 1'b1;
      w.wdata = alu_model(d.uop, d.op1, d.op2, d.op3.alu_imm);
    end
    return w;
  endfunction

  function automatic dispatch_t make_uop(input uop_e op, input logic [31:0] a,
                                         input logic [31:0] b, input logic [31:0] imm);
    dispatch_t d;
    d         = '0;
    d.val     = 1'b1;
    d.pc      = rand_word() & 32'hffff_fffc;
    d.seq_num = next_seq;
    d.op1     = a;
    d.op2     = b;
    d.waddr   = 5'(rand_word());
    d.uop     = op;
    d.preg    = 6'(rand_word());
    d.ppreg   = 6'(rand_word());
    if (is_control_flow(op)) begin
      d.op3.branch_imm = imm;
    end else begin
      d.op3.alu_imm = imm;
    end
    next_seq = next_seq + 1'b1;
    return d;
  endfunction

  // Equal, sign-boundary, zero/all-ones and random pairs
  task automatic pick_operands(input int v, output logic [31:0] a, output logic [31:0] b);
    case (v)
      0: begin
        a = rand_word();
        b = a;
      end
      1: begin
        a = 32'h7fff_ffff;
        b = 32'h8000_0000;
      end
      2: begin
        a = 32'h8000_0000;
        b = 32'h7fff_ffff;
      end
      3: begin
        a = 32'h0;
        b = 32'hffff_ffff;
      end
      default: begin
        a = rand_word();
        b = rand_word();
      end
    endcase
  endtask

  // ----------------------------------------------------------------------
  // Driving and checking tasks
  // ----------------------------------------------------------------------

  task automatic apply_reset();
    rst      = 1'b1;
    disp.val = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  endtask

  // Holds val until the accepting edge and ends on a falling edge
  task automatic issue(input dispatch_t d);
    int waited;
    waited = 0;
    @(negedge clk);
    disp     = d;
    disp.val = 1'b1;
    @(posedge clk);
    while (!disp_rdy) begin
      if (waited > 50) begin
        abort_run("Dispatch was not accepted within 50 cycles");
      end else begin
        waited++;
        @(posedge clk);
      end
    end
    @(negedge clk);
    disp.val = 1'b0;
  endtask

  task automatic wait_wb(input int n);
    int waited;
    waited = 0;
    while ((wb_q.size() - wb_rd) < n) begin
      if (waited > 40) begin
        abort_run("Writeback did not arrive within 40 cycles");
      end else begin
        waited++;
        @(negedge clk);
      end
    end
  endtask

  task automatic take_wb(output wb_t w);
    w = wb_q[wb_rd];
    wb_rd++;
  endtask

  task automatic check_wb(input wb_t got, input dispatch_t d);
    wb_t   exp;
    string tag;
    exp = model_wb(d);
    tag = $sformatf("uop %0d seq %0d", d.uop, d.seq_num);
    check_eq(got.pc, exp.pc, {tag, " pc"});
    check_eq(32'(got.seq_num), 32'(exp.seq_num), {tag, " seq_num"});
    check_eq(32'(got.waddr), 32'(exp.waddr), {tag, " waddr"});
    check_eq(32'(got.wen), 32'(exp.wen), {tag, " wen"});
    check_eq(32'(got.preg), 32'(exp.preg), {tag, " preg"});
    check_eq(32'(got.ppreg), 32'(exp.ppreg), {tag, " ppreg"});
    if (exp.wen) begin
      check_eq(got.wdata, exp.wdata, {tag, " wdata"});
    end
  endtask

  // Exactly one squash, one cycle after accept, when the model redirects
  task automatic check_squash(input dispatch_t d);
    logic [31:0] tgt;
    logic        taken;
    squash_t     s;
    int          at;
    taken = redirect_model(d, tgt);
    check_eq(32'(sq_q.size() - sq_rd), taken ? 32'd1 : 32'd0, "squash count");
    if (taken) begin
      s  = sq_q[sq_rd];
      at = sq_cyc_q[sq_rd];
      sq_rd++;
      check_eq(s.target, tgt, "squash target");
      check_eq(32'(s.seq_num), 32'(d.seq_num), "squash seq_num");
      check_eq(32'(at), 32'(cf_acc_cycle + 1), "squash cycle");
    end
  endtask

  task automatic run_cf(input dispatch_t d);
    wb_t got;
    issue(d);
    wait_wb(1);
    take_wb(got);
    check_wb(got, d);
    // Extra cycles would catch a repeated squash
    repeat (2) @(negedge clk);
    check_squash(d);
  endtask

  // ----------------------------------------------------------------------
  // Directed tests
  // ----------------------------------------------------------------------

  task automatic check_idle();
    @(posedge clk);
    check_eq(32'(wb_val), 32'd0, "wb_val after reset");
    check_eq(32'(squash.val), 32'd0, "squash.val after reset");
    check_eq(32'(disp_rdy), 32'd1, "disp_rdy after reset");
    @(negedge clk);
  endtask

  task automatic test_alu_ops();
    dispatch_t   d;
    logic [31:0] a;
    logic [31:0] b;
    wb_t         got;
    for (int k = 0; k < 8; k++) begin
      for (int v = 0; v < n_vec; v++) begin
        pick_operands(v, a, b);
        d = make_uop(uop_e'(4'(k)), a, b, rand_word());
        issue(d);
        wait_wb(1);
        take_wb(got);
        check_wb(got, d);
      end
    end
  endtask

  task automatic test_branches();
    dispatch_t   d;
    logic [31:0] a;
    logic [31:0] b;
    for (int k = 0; k < 6; k++) begin
      for (int v = 0; v < n_vec; v++) begin
        pick_operands(v, a, b);
        d = make_uop(uop_e'(4'(8 + k)), a, b, branch_offset(rand_word()));
        run_cf(d);
      end
    end
  endtask

  // Odd op1 values exercise the bit-0 clear of JALR
  task automatic test_jumps();
    dispatch_t d;
    for (int v = 0; v < 4; v++) begin
      d = make_uop(OP_JAL, rand_word(), rand_word(), branch_offset(rand_word()));
      run_cf(d);
      d = make_uop(OP_JALR, rand_word(), rand_word(), branch_offset(rand_word()));
      run_cf(d);
    end
  endtask

  task automatic test_backpressure();
    dispatch_t a_op;
    dispatch_t b_op;
    dispatch_t c_op;
    wb_t       view;
    wb_t       got;
    int        seen_a;
    int        seen_b;
    seen_a = 0;
    seen_b = 0;
    a_op = make_uop(OP_SUB, rand_word(), rand_word(), 32'd0);
    b_op = make_uop(OP_BNE, 32'd1, 32'd2, branch_offset(rand_word()));
    c_op = make_uop(OP_ADD, rand_word(), rand_word(), 32'd0);
    @(negedge clk);
    wb_rdy = 1'b0;
    issue(a_op);
    issue(b_op);
    // Both units full, a third micro-op must wait
    disp = c_op;
    @(posedge clk);
    view = wb;
    repeat (6) begin
      check_eq(32'(disp_rdy), 32'd0, "disp_rdy while both units hold");
      check_eq(32'(wb_val), 32'd1, "wb_val while stalled");
      check_eq(wb.pc, view.pc, "stalled wb.pc");
      check_eq(wb.wdata, view.wdata, "stalled wb.wdata");
      check_eq(32'(wb.seq_num), 32'(view.seq_num), "stalled wb.seq_num");
      @(posedge clk);
    end
    @(negedge clk);
    disp.val = 1'b0;
    check_squash(b_op);
    wb_rdy = 1'b1;
    wait_wb(2);
    repeat (3) @(negedge clk);
    check_eq(32'(wb_q.size() - wb_rd), 32'd2, "writebacks after release");
    repeat (2) begin
      take_wb(got);
      if (got.seq_num == a_op.seq_num) begin
        check_wb(got, a_op);
        seen_a++;
      end else begin
        check_wb(got, b_op);
        seen_b++;
      end
    end
    check_eq(32'(seen_a), 32'd1, "ALU result count");
    check_eq(32'(seen_b), 32'd1, "branch result count");
    check_eq(32'(sq_q.size() - sq_rd), 32'd0, "squash repeated after release");
  endtask

  // Priority goes to the unit that did not transfer last
  task automatic test_round_robin();
    dispatch_t a_op;
    dispatch_t b_op;
    wb_t       got;
    logic      alu_first;
    apply_reset();
    check_idle();
    alu_first = 1'b1;
    for (int round = 0; round < 3; round++) begin
      @(negedge clk);
      wb_rdy = 1'b0;
      a_op = make_uop(OP_XOR, rand_word(), rand_word(), 32'd0);
      b_op = make_uop(OP_BEQ, 32'd5, 32'd6, branch_offset(rand_word()));
      issue(a_op);
      // Middle round sends the ALU op alone
      if (round != 1) begin
        issue(b_op);
      end
      wb_rdy = 1'b1;
      wait_wb((round == 1) ? 1 : 2);
      if (round == 1) begin
        take_wb(got);
        check_wb(got, a_op);
        alu_first = 1'b0;
      end else if (alu_first) begin
        take_wb(got);
        check_wb(got, a_op);
        take_wb(got);
        check_wb(got, b_op);
        alu_first = 1'b1;
      end else begin
        take_wb(got);
        check_wb(got, b_op);
        take_wb(got);
        check_wb(got, a_op);
        alu_first = 1'b0;
      end
    end
  endtask

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------

  initial begin
    rst    = 1'b1;
    disp   = '0;
    wb_rdy = 1'b1;
    apply_reset();
    check_idle();
    test_alu_ops();
    test_branches();
    test_jumps();
    test_backpressure();
    test_round_robin();
    repeat (4) @(negedge clk);
    if (wb_q.size() == wb_rd && sq_q.size() == sq_rd) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      abort_run("Unexpected writebacks or squashes were left at the end");
    end
  end

endmodule

/* build.f */
rtl/exec_pkg.sv
rtl/dispatch_router.sv
rtl/alu_unit.sv
rtl/control_flow_unit.sv
rtl/wb_arbiter.sv
rtl/execute_top.sv
tb/tb_clock_gen.sv
tb/execute_tb.sv

/* run.sh */
#!/bin/sh
# Compile the execute-stage testbench with Verilator and run it.
# The log is searched for the pass line to decide the result.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module execute_tb -f build.f -o execute_sim

# A fatal stop ends the simulator with an error status; the log decides
./obj_dir/execute_sim > sim.log 2>&1 || true
cat sim.log

if grep -qF '*** PASSED ***' sim.log; then
  echo "Simulation result: pass"
else
  echo "Simulation result: fail"
  exit 1
fi
